/* Bender.yml */
package:
  name: u2_core_ctrl

sources:
  - include_dirs:
      - source
    files:
      - source/u2_bus_pkg.sv
      - source/u2_ctrl_pkg.sv
      - source/wb_slave_if.sv
      - source/wb_page_decoder.sv
      - source/settings_bank.sv
      - source/status_readback.sv
      - source/irq_controller.sv
      - source/u2_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/tb_u2_core.sv

/* bench/tb_u2_core.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the control slice with bus tasks and output checks
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "u2_defs.svh"

module tb_u2_core;
   import u2_bus_pkg::*;
   import u2_ctrl_pkg::*;

   localparam int          CLK_PERIOD     = 4;
   localparam int          RESET_CYCLES   = 8;
   localparam int          ROUNDS         = 24;
   // Budget per round in accesses, cycles per access and idle cycles
   localparam int          ROUND_ACCESSES = 24;
   localparam int          ACCESS_CYCLES  = 6;
   localparam int          ROUND_IDLE     = 20;
   localparam int          TIMEOUT_NS     = 2 * CLK_PERIOD * (RESET_CYCLES
                                            + ROUNDS * (ROUND_ACCESSES * ACCESS_CYCLES
                                            + ROUND_IDLE));
   localparam int unsigned SEED           = 32'hff95_6981;

   logic       dsp_clk;
   logic       wb_rst;
   logic       wb_cyc_i;
   logic       wb_stb_i;
   logic       wb_we_i;
   wb_adr_t    wb_adr_i;
   wb_dat_t    wb_dat_i;
   wb_dat_t    wb_dat_o;
   logic       wb_ack_o;
   logic       clk_status_i;
   logic       serdes_link_up_i;
   logic       sim_mode_i;
   logic [3:0] clock_divider_i;
   logic [4:0] irq_src_i;
   logic       phy_int_n_i;
   logic       clock_ready_o;
   logic       ser_enable_o;
   logic       ser_prbsen_o;
   logic       ser_loopen_o;
   logic       ser_rx_en_o;
   logic       adc_oe_a_o;
   logic       adc_on_a_o;
   logic       adc_oe_b_o;
   logic       adc_on_b_o;
   logic       phy_resetn_o;
   logic       int_o;
   logic [1:0] clk_en_o;
   logic [1:0] clk_sel_o;
   ctrl_byte_t leds_o;

   // Expected settings register contents by word address
   logic [7:0]  model_reg [0:8];
   int          cycle_count = 0;
   int          last_ack_cycle;

   u2_core uut (.*);

   initial begin
      dsp_clk = 1'b0;
      forever #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;
   end

   always @(posedge dsp_clk)
      cycle_count <= cycle_count + 1;

   //////////////////////////////////////////////////////////////////////
   // Failure reporting
   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic flag_mismatch(input string what);
      stop_with_failure($sformatf("Mismatch at %0t: %s", $time, what));
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
         else flag_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
   endtask

   // Handshake rules on the host port
   assert property (@(posedge dsp_clk) disable iff (wb_rst)
                    (wb_cyc_i && wb_stb_i && !wb_ack_o) |=> wb_ack_o)
      else stop_with_failure("Handshake error: no ack on the cycle after stb");
   assert property (@(posedge dsp_clk) disable iff (wb_rst) wb_ack_o |=> !wb_ack_o)
      else stop_with_failure("Handshake error: ack held for more than one cycle");
   assert property (@(posedge dsp_clk) disable iff (wb_rst)
                    wb_ack_o |-> (wb_cyc_i && wb_stb_i))
      else stop_with_failure("Handshake error: ack without cyc and stb");

   //////////////////////////////////////////////////////////////////////
   // Bus tasks
   function automatic wb_adr_t make_addr(input int page, input int word);
      return wb_adr_t'(page * 256 + word * 4);
   endfunction

   task automatic bus_access(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                             output wb_dat_t rdata);
      int edges;
      repeat ($urandom_range(3, 0)) @(posedge dsp_clk);
      @(posedge dsp_clk);
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      wb_we_i  <= we;
      wb_adr_i <= adr;
      wb_dat_i <= dat;
      edges = 0;
      do begin
         @(posedge dsp_clk);
         edges++;
      end while (!wb_ack_o);
      // Ack is due on the second edge after stb is driven
      assert (edges == 2)
         else stop_with_failure($sformatf("Handshake error at %0t: ack after %0d edges",
                                          $time, edges));
      rdata          = wb_dat_o;
      last_ack_cycle = cycle_count;
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i  <= 1'b0;
   endtask

   task automatic write_word(input wb_adr_t adr, input wb_dat_t dat);
      wb_dat_t unused;
      bus_access(1'b1, adr, dat, unused);
   endtask

   task automatic read_word(input wb_adr_t adr, output wb_dat_t dat);
      bus_access(1'b0, adr, $urandom, dat);
   endtask

   // Drives source idx of the interrupt vector where bit 5 is the inverted PHY line
   task automatic set_source(input int idx, input logic level);
      @(posedge dsp_clk);
      case (idx)
         5:       phy_int_n_i      <= ~level;
         6:       serdes_link_up_i <= level;
         7:       clk_status_i     <= level;
         default: irq_src_i[idx]   <= level;
      endcase
   endtask

   //////////////////////////////////////////////////////////////////////
   // Checks per behavior
   task automatic check_controls();
      logic [7:0] hw;
      logic [7:0] leds_exp;
      int         i;
      hw = {6'b0, clk_status_i, serdes_link_up_i};
      for (i = 0; i < 8; i++)
         leds_exp[i] = model_reg[`U2_SR_LED_SRC][i] ? hw[i] : model_reg[`U2_SR_LED][i];
      check_value("clock outputs", 32'({clock_ready_o, clk_en_o, clk_sel_o}),
                  32'(model_reg[`U2_SR_CLOCK][4:0]));
      check_value("serdes outputs",
                  32'({ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o}),
                  32'(model_reg[`U2_SR_SERDES][3:0]));
      check_value("ADC outputs", 32'({adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}),
                  32'(model_reg[`U2_SR_ADC][3:0]));
      check_value("phy_resetn_o", 32'(phy_resetn_o), 32'(!model_reg[`U2_SR_PHY][0]));
      check_value("leds_o", 32'(leds_o), 32'(leds_exp));
   endtask

   task automatic settings_round();
      int      regs[4];
      int      page;
      wb_dat_t val;
      wb_dat_t rd;
      regs = '{`U2_SR_CLOCK, `U2_SR_SERDES, `U2_SR_ADC, `U2_SR_PHY};
      foreach (regs[i]) begin
         val = $urandom;
         write_word(make_addr(`U2_PAGE_SETTINGS, regs[i]), val);
         model_reg[regs[i]] = val[7:0];
         check_controls();
      end
      read_word(make_addr(`U2_PAGE_SETTINGS, $urandom_range(63, 0)), rd);
      check_value("settings page read", rd, 0);
      page = $urandom_range(255, 3);
      write_word(make_addr(page, $urandom_range(63, 0)), $urandom);
      check_controls();
      read_word(make_addr(page, $urandom_range(63, 0)), rd);
      check_value("unmapped page read", rd, 0);
   endtask

   task automatic led_round();
      logic [7:0] sw;
      logic [7:0] src;
      sw  = 8'($urandom);
      src = 8'($urandom);
      write_word(make_addr(`U2_PAGE_SETTINGS, `U2_SR_LED), 32'(sw));
      model_reg[`U2_SR_LED] = sw;
      write_word(make_addr(`U2_PAGE_SETTINGS, `U2_SR_LED_SRC), 32'(src));
      model_reg[`U2_SR_LED_SRC] = src;
      check_controls();
      @(posedge dsp_clk);
      clk_status_i     <= 1'($urandom_range(1, 0));
      serdes_link_up_i <= 1'($urandom_range(1, 0));
      @(posedge dsp_clk);
      check_controls();
   endtask

   task automatic readback_round();
      wb_dat_t    rd;
      wb_dat_t    first_cnt;
      int         first_ack;
      logic [7:0] vec_exp;
      @(posedge dsp_clk);
      sim_mode_i       <= 1'($urandom_range(1, 0));
      clock_divider_i  <= 4'($urandom);
      irq_src_i        <= 5'($urandom);
      phy_int_n_i      <= 1'($urandom_range(1, 0));
      serdes_link_up_i <= 1'($urandom_range(1, 0));
      clk_status_i     <= 1'($urandom_range(1, 0));
      repeat (2) @(posedge dsp_clk);
      vec_exp = {clk_status_i, serdes_link_up_i, ~phy_int_n_i, irq_src_i};
      read_word(make_addr(`U2_PAGE_READBACK, 1), rd);
      check_value("IRQ level word", rd, 32'(vec_exp));
      write_word(make_addr(`U2_PAGE_READBACK, $urandom_range(15, 0)), $urandom);
      read_word(make_addr(`U2_PAGE_READBACK, 0), rd);
      check_value("strap word", rd, {sim_mode_i, 27'b0, clock_divider_i});
      read_word(make_addr(`U2_PAGE_READBACK, $urandom_range(15, 3)), rd);
      check_value("spare readback word", rd, 0);
      read_word(make_addr(`U2_PAGE_READBACK, 2), first_cnt);
      first_ack = last_ack_cycle;
      read_word(make_addr(`U2_PAGE_READBACK, 2), rd);
      check_value("cycle count delta", rd - first_cnt, 32'(last_ack_cycle - first_ack));
   endtask

   task automatic irq_round();
      wb_dat_t    rd;
      logic [7:0] mask;
      logic [7:0] pend_exp;
      int         k1;
      int         k2;
      int         idx_exp;
      int         i;
      mask     = 8'($urandom);
      k1       = $urandom_range(7, 0);
      k2       = $urandom_range(7, 0);
      pend_exp = 8'(1 << k1) | 8'(1 << k2);
      idx_exp  = 8;
      for (i = 0; i < 8; i++)
         if (idx_exp == 8 && pend_exp[i] && mask[i])
            idx_exp = i;
      // Quiet all sources before clearing pending
      @(posedge dsp_clk);
      irq_src_i        <= '0;
      phy_int_n_i      <= 1'b1;
      serdes_link_up_i <= 1'b0;
      clk_status_i     <= 1'b0;
      repeat (3) @(posedge dsp_clk);
      write_word(make_addr(`U2_PAGE_PIC, 1), 32'hff);
      check_value("int_o after clear", 32'(int_o), 0);
      write_word(make_addr(`U2_PAGE_PIC, 0), 32'(mask));
      read_word(make_addr(`U2_PAGE_PIC, 0), rd);
      check_value("mask word", rd, 32'(mask));
      set_source(k1, 1'b1);
      set_source(k2, 1'b1);
      repeat (3) @(posedge dsp_clk);
      check_value("int_o with pending", 32'(int_o), 32'(|(pend_exp & mask)));
      read_word(make_addr(`U2_PAGE_PIC, 1), rd);
      check_value("pending word", rd, 32'(pend_exp));
      read_word(make_addr(`U2_PAGE_PIC, 2), rd);
      check_value("lowest index word", rd, 32'(idx_exp));
      write_word(make_addr(`U2_PAGE_PIC, 1), 32'(pend_exp));
      check_value("int_o after pending write", 32'(int_o), 0);
      read_word(make_addr(`U2_PAGE_PIC, 1), rd);
      check_value("pending after clear", rd, 0);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   initial begin
      int r;
      void'($urandom(SEED));
      foreach (model_reg[i])
         model_reg[i] = '0;
      wb_rst           <= 1'b1;
      wb_cyc_i         <= 1'b0;
      wb_stb_i         <= 1'b0;
      wb_we_i          <= 1'b0;
      wb_adr_i         <= '0;
      wb_dat_i         <= '0;
      clk_status_i     <= 1'b0;
      serdes_link_up_i <= 1'b0;
      sim_mode_i       <= 1'b0;
      clock_divider_i  <= '0;
      irq_src_i        <= '0;
      phy_int_n_i      <= 1'b1;
      repeat (RESET_CYCLES) @(posedge dsp_clk);
      wb_rst <= 1'b0;
      @(posedge dsp_clk);
      check_controls();
      check_value("int_o after reset", 32'(int_o), 0);
      check_value("wb_ack_o after reset", 32'(wb_ack_o), 0);
      for (r = 0; r < ROUNDS; r++) begin
         settings_round();
         led_round();
         readback_round();
         irq_round();
      end
      $display("*** PASSED ***");
      $finish;
   end

   // Watchdog
   initial begin
      #(TIMEOUT_NS);
      stop_with_failure("Watchdog timeout: the tests did not finish in time");
   end

endmodule

/* sim.f */
+incdir+source
source/u2_bus_pkg.sv
source/u2_ctrl_pkg.sv
source/wb_slave_if.sv
source/wb_page_decoder.sv
source/settings_bank.sv
source/status_readback.sv
source/irq_controller.sv
source/u2_core.sv
bench/tb_u2_core.sv

/* source/irq_controller.sv */
//////////////////////////////////////////////////////////////////////
// Interrupt controller: edge pending, mask, lowest-index encode
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "u2_defs.svh"

module irq_controller (
   input  logic                  dsp_clk,
   input  logic                  wb_rst,
   wb_slave_if.slave             bus,
   input  logic [4:0]            irq_src_i,
   input  logic                  phy_int_n_i,
   input  logic                  serdes_link_up_i,
   input  logic                  clk_status_i,
   output u2_ctrl_pkg::irq_vec_t irq_level_o,
   output logic                  int_o
);
   import u2_bus_pkg::*;
   import u2_ctrl_pkg::*;

   irq_vec_t   src_q;
   irq_vec_t   prev_q;
   irq_vec_t   rising;
   irq_vec_t   clr;
   irq_vec_t   pend_q;
   irq_vec_t   mask_q;
   irq_vec_t   active;
   irq_idx_t   first_idx;
   logic       ack_q;
   logic       accept;
   logic       wr_stb;
   logic [2:0] word;
   wb_dat_t    rd_mux;
   wb_dat_t    rd_q;

   assign accept = bus.cyc & bus.stb & ~ack_q;
   assign wr_stb = accept & bus.we;
   assign word   = bus.adr[4:2];

   //////////////////////////////////////////////////////////////////////
   // Source sampling and edge detect
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         src_q  <= '0;
         prev_q <= '0;
      end else begin
         src_q  <= {clk_status_i, serdes_link_up_i, ~phy_int_n_i, irq_src_i};
         prev_q <= src_q;
      end
   end

   assign rising      = src_q & ~prev_q;
   assign irq_level_o = src_q;

   // Write of 1 to word 1 clears, a fresh edge wins
   assign clr = (wr_stb && word == 3'd1) ? bus.dat_w[`U2_NUM_IRQ-1:0] : '0;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         ack_q  <= 1'b0;
         pend_q <= '0;
         mask_q <= '0;
      end else begin
         ack_q  <= accept;
         pend_q <= (pend_q & ~clr) | rising;
         if (wr_stb && word == 3'd0)
            mask_q <= bus.dat_w[`U2_NUM_IRQ-1:0];
      end
   end

   assign active = pend_q & mask_q;
   assign int_o  = |active;

   //////////////////////////////////////////////////////////////////////
   // Lowest active index
   always_comb begin
      first_idx = irq_idx_t'(`U2_NUM_IRQ);
      for (int i = `U2_NUM_IRQ - 1; i >= 0; i--) begin
         if (active[i])
            first_idx = irq_idx_t'(i);
      end
   end

   always_comb begin
      case (word)
         3'd0:    rd_mux = wb_dat_t'(mask_q);
         3'd1:    rd_mux = wb_dat_t'(pend_q);
         3'd2:    rd_mux = wb_dat_t'(first_idx);
         default: rd_mux = '0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (accept)
         rd_q <= rd_mux;
   end

   assign bus.ack   = ack_q;
   assign bus.dat_r = rd_q;

endmodule

/* source/settings_bank.sv */
//////////////////////////////////////////////////////////////////////
// Settings bank: write-only board control registers and LED select
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "u2_defs.svh"

module settings_bank (
   input  logic                    dsp_clk,
   input  logic                    wb_rst,
   wb_slave_if.slave               bus,
   input  logic                    clk_status_i,
   input  logic                    serdes_link_up_i,
   output logic                    clock_ready_o,
   output logic [1:0]              clk_en_o,
   output logic [1:0]              clk_sel_o,
   output logic                    ser_enable_o,
   output logic                    ser_prbsen_o,
   output logic                    ser_loopen_o,
   output logic                    ser_rx_en_o,
   output logic                    adc_oe_a_o,
   output logic                    adc_on_a_o,
   output logic                    adc_oe_b_o,
   output logic                    adc_on_b_o,
   output logic                    phy_resetn_o,
   output u2_ctrl_pkg::ctrl_byte_t leds_o
);
   import u2_bus_pkg::*;
   import u2_ctrl_pkg::*;

   logic       ack_q;
   logic       set_stb;
   set_addr_t  set_addr;
   set_data_t  set_data;
   ctrl_byte_t clock_q;
   ctrl_byte_t serdes_q;
   ctrl_byte_t adc_q;
   ctrl_byte_t led_sw_q;
   ctrl_byte_t phy_q;
   ctrl_byte_t led_src_q;
   ctrl_byte_t led_hw;

   //////////////////////////////////////////////////////////////////////
   // Bus side, write becomes a settings strobe
   always_ff @(posedge dsp_clk) begin
      if (wb_rst)
         ack_q <= 1'b0;
      else
         ack_q <= bus.cyc & bus.stb & ~ack_q;
   end

   // Strobe lands on the same edge that raises ack
   assign set_stb  = bus.cyc & bus.stb & bus.we & ~ack_q;
   assign set_addr = bus.adr[9:2];
   assign set_data = bus.dat_w;

   assign bus.ack   = ack_q;
   assign bus.dat_r = '0;

   //////////////////////////////////////////////////////////////////////
   // Control registers, low byte only
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         clock_q   <= '0;
         serdes_q  <= '0;
         adc_q     <= '0;
         led_sw_q  <= '0;
         phy_q     <= '0;
         led_src_q <= '0;
      end else if (set_stb) begin
         case (set_addr)
            `U2_SR_CLOCK:   clock_q   <= set_data[7:0];
            `U2_SR_SERDES:  serdes_q  <= set_data[7:0];
            `U2_SR_ADC:     adc_q     <= set_data[7:0];
            `U2_SR_LED:     led_sw_q  <= set_data[7:0];
            `U2_SR_PHY:     phy_q     <= set_data[7:0];
            `U2_SR_LED_SRC: led_src_q <= set_data[7:0];
            default: ;
         endcase
      end
   end

   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_q[4:0];
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = serdes_q[3:0];
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_q[3:0];

   // PHY held in reset while bit 0 is set
   assign phy_resetn_o = ~phy_q[0];

   // LED select, 1 = hardware, 0 = software
   assign led_hw = {6'b0, clk_status_i, serdes_link_up_i};
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

/* source/status_readback.sv */
//////////////////////////////////////////////////////////////////////
// Status readback: strap inputs, IRQ levels, free-running counter
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module status_readback (
   input  logic                  dsp_clk,
   input  logic                  wb_rst,
   wb_slave_if.slave             bus,
   input  logic                  sim_mode_i,
   input  logic [3:0]            clock_divider_i,
   input  u2_ctrl_pkg::irq_vec_t irq_level_i
);
   import u2_bus_pkg::*;
   import u2_ctrl_pkg::*;

   logic       ack_q;
   logic       accept;
   logic [3:0] word;
   cycle_cnt_t cnt_q;
   wb_dat_t    word_mux;
   wb_dat_t    rd_q;

   assign accept = bus.cyc & bus.stb & ~ack_q;
   assign word   = bus.adr[5:2];

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         ack_q <= 1'b0;
         cnt_q <= '0;
      end else begin
         ack_q <= accept;
         cnt_q <= cnt_q + 1'b1;
      end
   end

   // Words past 2 read zero, writes only get the ack
   always_comb begin
      case (word)
         4'd0:    word_mux = {sim_mode_i, 27'b0, clock_divider_i};
         4'd1:    word_mux = wb_dat_t'(irq_level_i);
         4'd2:    word_mux = wb_dat_t'(cnt_q);
         default: word_mux = '0;
      endcase
   end

   // Captured on the ack edge
   always_ff @(posedge dsp_clk) begin
      if (accept)
         rd_q <= word_mux;
   end

   assign bus.ack   = ack_q;
   assign bus.dat_r = rd_q;

endmodule

/* source/u2_bus_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Bus-side types for the host port and the settings strobe
//////////////////////////////////////////////////////////////////////
`include "u2_defs.svh"

package u2_bus_pkg;

   // Byte address on the host bus
   typedef logic [`U2_WB_AW-1:0] wb_adr_t;

   // One bus data word
   typedef logic [`U2_WB_DW-1:0] wb_dat_t;

   // Settings word address, host address bits 9:2
   typedef logic [7:0] set_addr_t;

   // Settings payload, always a full word
   typedef logic [`U2_WB_DW-1:0] set_data_t;

endpackage

/* source/u2_core.sv */
//////////////////////////////////////////////////////////////////////
// Radio mainboard control slice: host port, settings, status, PIC
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module u2_core (
   input  logic                    dsp_clk,
   input  logic                    wb_rst,
   // Host Wishbone port
   input  logic                    wb_cyc_i,
   input  logic                    wb_stb_i,
   input  logic                    wb_we_i,
   input  u2_bus_pkg::wb_adr_t     wb_adr_i,
   input  u2_bus_pkg::wb_dat_t     wb_dat_i,
   output u2_bus_pkg::wb_dat_t     wb_dat_o,
   output logic                    wb_ack_o,
   // Board status inputs
   input  logic                    clk_status_i,
   input  logic                    serdes_link_up_i,
   input  logic                    sim_mode_i,
   input  logic [3:0]              clock_divider_i,
   input  logic [4:0]              irq_src_i,
   input  logic                    phy_int_n_i,
   // Board control outputs
   output logic                    clock_ready_o,
   output logic [1:0]              clk_en_o,
   output logic [1:0]              clk_sel_o,
   output logic                    ser_enable_o,
   output logic                    ser_prbsen_o,
   output logic                    ser_loopen_o,
   output logic                    ser_rx_en_o,
   output logic                    adc_oe_a_o,
   output logic                    adc_on_a_o,
   output logic                    adc_oe_b_o,
   output logic                    adc_on_b_o,
   output logic                    phy_resetn_o,
   output u2_ctrl_pkg::ctrl_byte_t leds_o,
   output logic                    int_o
);
   import u2_ctrl_pkg::*;

   irq_vec_t irq_level;

   wb_slave_if host_bus ();
   wb_slave_if settings_bus ();
   wb_slave_if readback_bus ();
   wb_slave_if pic_bus ();

   assign host_bus.cyc   = wb_cyc_i;
   assign host_bus.stb   = wb_stb_i;
   assign host_bus.we    = wb_we_i;
   assign host_bus.adr   = wb_adr_i;
   assign host_bus.dat_w = wb_dat_i;
   assign wb_dat_o       = host_bus.dat_r;
   assign wb_ack_o       = host_bus.ack;

   wb_page_decoder decoder (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .host(host_bus),
      .settings_bus(settings_bus), .readback_bus(readback_bus), .pic_bus(pic_bus)
   );

   settings_bank settings (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .bus(settings_bus),
      .clk_status_i(clk_status_i), .serdes_link_up_i(serdes_link_up_i),
      .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .phy_resetn_o(phy_resetn_o), .leds_o(leds_o)
   );

   status_readback readback (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .bus(readback_bus),
      .sim_mode_i(sim_mode_i), .clock_divider_i(clock_divider_i),
      .irq_level_i(irq_level)
   );

   irq_controller pic (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .bus(pic_bus),
      .irq_src_i(irq_src_i), .phy_int_n_i(phy_int_n_i),
      .serdes_link_up_i(serdes_link_up_i), .clk_status_i(clk_status_i),
      .irq_level_o(irq_level), .int_o(int_o)
   );

endmodule

/* source/u2_ctrl_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Control-side types: register bytes, interrupts, cycle count
//////////////////////////////////////////////////////////////////////
`include "u2_defs.svh"

package u2_ctrl_pkg;

   // Content of one board control register
   typedef logic [7:0] ctrl_byte_t;

   // Source vector
   // 4:0 irq_src, 5 PHY interrupt (active high), 6 link up, 7 clock status
   typedef logic [`U2_NUM_IRQ-1:0] irq_vec_t;

   // Encoded lowest active source, 8 when nothing is pending
   typedef logic [3:0] irq_idx_t;

   // Free-running cycle counter
   typedef logic [31:0] cycle_cnt_t;

endpackage

/* source/u2_defs.svh */
//////////////////////////////////////////////////////////////////////
// Control slice map: bus widths, page numbers, settings addresses
//////////////////////////////////////////////////////////////////////
`ifndef U2_DEFS_SVH
`define U2_DEFS_SVH

`define U2_WB_AW 16
`define U2_WB_DW 32

// Address bits 15:8 select the slave
`define U2_PAGE_SETTINGS 0
`define U2_PAGE_READBACK 1
`define U2_PAGE_PIC      2

// Settings word addresses
`define U2_SR_CLOCK   0
`define U2_SR_SERDES  1
`define U2_SR_ADC     2
`define U2_SR_LED     3
`define U2_SR_PHY     4
`define U2_SR_LED_SRC 8

`define U2_NUM_IRQ 8

`endif

/* source/wb_page_decoder.sv */
//////////////////////////////////////////////////////////////////////
// Page decoder: steers host cycles to the slave picked by adr[15:8]
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "u2_defs.svh"

module wb_page_decoder (
   input  logic       dsp_clk,
   input  logic       wb_rst,
   wb_slave_if.slave  host,
   wb_slave_if.master settings_bus,
   wb_slave_if.master readback_bus,
   wb_slave_if.master pic_bus
);

   logic [7:0] page;
   logic       sel_set;
   logic       sel_rb;
   logic       sel_pic;
   logic       sel_none;
   logic       unm_ack;

   assign page     = host.adr[`U2_WB_AW-1:8];
   assign sel_set  = (page == 8'(`U2_PAGE_SETTINGS));
   assign sel_rb   = (page == 8'(`U2_PAGE_READBACK));
   assign sel_pic  = (page == 8'(`U2_PAGE_PIC));
   assign sel_none = ~(sel_set | sel_rb | sel_pic);

   //////////////////////////////////////////////////////////////////////
   // Fan out, stb only to the selected page
   assign settings_bus.cyc   = host.cyc;
   assign settings_bus.stb   = host.stb & sel_set;
   assign settings_bus.we    = host.we;
   assign settings_bus.adr   = host.adr;
   assign settings_bus.dat_w = host.dat_w;

   assign readback_bus.cyc   = host.cyc;
   assign readback_bus.stb   = host.stb & sel_rb;
   assign readback_bus.we    = host.we;
   assign readback_bus.adr   = host.adr;
   assign readback_bus.dat_w = host.dat_w;

   assign pic_bus.cyc   = host.cyc;
   assign pic_bus.stb   = host.stb & sel_pic;
   assign pic_bus.we    = host.we;
   assign pic_bus.adr   = host.adr;
   assign pic_bus.dat_w = host.dat_w;

   // Unmapped pages answer here, same one-cycle timing
   always_ff @(posedge dsp_clk) begin
      if (wb_rst)
         unm_ack <= 1'b0;
      else
         unm_ack <= host.cyc & host.stb & sel_none & ~unm_ack;
   end

   //////////////////////////////////////////////////////////////////////
   // Return path
   assign host.ack = settings_bus.ack | readback_bus.ack | pic_bus.ack | unm_ack;

   always_comb begin
      if (sel_set)
         host.dat_r = settings_bus.dat_r;
      else if (sel_rb)
         host.dat_r = readback_bus.dat_r;
      else if (sel_pic)
         host.dat_r = pic_bus.dat_r;
      else
         host.dat_r = '0;
   end

endmodule

/* source/wb_slave_if.sv */
//////////////////////////////////////////////////////////////////////
// Wishbone classic link, no sel, err or rty
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface wb_slave_if;
   import u2_bus_pkg::*;

   logic    cyc;
   logic    stb;
   logic    we;
   wb_adr_t adr;
   wb_dat_t dat_w;
   wb_dat_t dat_r;
   logic    ack;

   // Cycle owner
   modport master (
      output cyc, stb, we, adr, dat_w,
      input  dat_r, ack
   );

   // Responder, one-cycle ack
   modport slave (
      input  cyc, stb, we, adr, dat_w,
      output dat_r, ack
   );

endinterface
